//--- common/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Cache geometry, 4 KB direct mapped
`define CACHE_LINES     256
`define CACHE_INDEX_W   8
`define CACHE_OFFSET_W  4
`define CACHE_TAG_W     20
`define CACHE_LINE_W    128
`define CACHE_WORD_W    32

// Backing line memory
`define MEM_LINES       1024
`define MEM_LATENCY     3      // Strobe to ack, in cycles

`endif

//--- common/cache_pkg.sv
`default_nettype none
`include "cache_macros.svh"

package cache_pkg;

    // Processor byte address as seen by the cache
    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]    tag;
        logic [`CACHE_INDEX_W-1:0]  index;
        logic [`CACHE_OFFSET_W-1:0] offset;
    } cache_addr_t;

    typedef struct packed {
        logic wr_en;        // Word write into the addressed line
        logic rd_en;        // Word read out
        logic mem_wr;       // Launch victim writeback
        logic mem_rd;       // Fetch level, install on ack
        logic clean_step;   // Advance flush index
        logic clean_hold;   // Keep flush index while waiting
    } ctrl_cmd_t;

    typedef struct packed {
        logic [31:0]              addr;  // Line aligned
        logic [`CACHE_LINE_W-1:0] data;
        logic                     rd;
        logic                     wr;
    } mem_req_t;

    typedef struct packed {
        logic [`CACHE_LINE_W-1:0] data;
        logic                     ack;
    } mem_rsp_t;

    typedef struct packed {
        logic hit;
        logic victim_dirty;
        logic flush_dirty;
        logic flush_last;
    } dp_status_t;

    typedef enum logic [2:0] {
        IDLE, COMPARE, WRITEBACK, FETCH, FLUSH_SCAN, FLUSH_WB, FLUSH_DONE
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- cache/cache_datapath.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module cache_datapath (
    input  wire                         clk,
    input  wire                         rst,
    input  wire cache_pkg::cache_addr_t cpu_addr_i,
    input  wire [`CACHE_WORD_W-1:0]     cpu_wdata_i,
    input  wire cache_pkg::ctrl_cmd_t   cmd_i,
    input  wire cache_pkg::mem_rsp_t    mem_rsp_i,
    output cache_pkg::mem_req_t         mem_req_o,
    output logic [`CACHE_WORD_W-1:0]    rdata_o,
    output cache_pkg::dp_status_t       status_o
);
    logic [`CACHE_LINE_W-1:0]   line_mem [`CACHE_LINES];
    logic [`CACHE_TAG_W-1:0]    tag_mem [`CACHE_LINES];
    logic [`CACHE_LINES-1:0]    valid_q;
    logic [`CACHE_LINES-1:0]    dirty_q;
    logic [`CACHE_INDEX_W:0]    flush_cnt;     // Extra bit to step past the last index
    logic [`CACHE_INDEX_W-1:0]  idx;
    logic [`CACHE_INDEX_W-1:0]  victim_idx;
    logic [1:0]                 word_sel;
    logic [`CACHE_LINE_W-1:0]   cur_line;
    logic                       fill;
    logic                       fetch_start;
    logic                       fetch_q;
    logic                       rd_stb_q;
    logic                       wr_stb_q;
    logic [31:0]                mem_addr_q;
    logic [`CACHE_LINE_W-1:0]   mem_data_q;

    assign idx         = cpu_addr_i.index;
    assign word_sel    = cpu_addr_i.offset[3:2];
    assign cur_line    = line_mem[idx];
    assign fill        = cmd_i.mem_rd && mem_rsp_i.ack;
    assign fetch_start = cmd_i.mem_rd && !fetch_q;    // First cycle of the fetch level

    // Flush walks its own index, normal misses evict the requested one
    assign victim_idx = cmd_i.clean_hold ? flush_cnt[`CACHE_INDEX_W-1:0] : idx;

    always_comb
    begin
        status_o.hit          = valid_q[idx] && (tag_mem[idx] == cpu_addr_i.tag);
        status_o.victim_dirty = valid_q[idx] && dirty_q[idx];
        status_o.flush_dirty  = dirty_q[flush_cnt[`CACHE_INDEX_W-1:0]];
        status_o.flush_last   = (flush_cnt == `CACHE_LINES - 1);
    end

    always_comb
    begin
        if (cmd_i.rd_en)
            rdata_o = cur_line[word_sel*`CACHE_WORD_W +: `CACHE_WORD_W];
        else
            rdata_o = '0;
    end

    // Line and tag storage
    always_ff @(posedge clk)
    begin
        if (fill)
        begin
            line_mem[idx] <= mem_rsp_i.data;
            tag_mem[idx]  <= cpu_addr_i.tag;
        end
        else if (cmd_i.wr_en)
        begin
            line_mem[idx][word_sel*`CACHE_WORD_W +: `CACHE_WORD_W] <= cpu_wdata_i;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            valid_q <= '0;
            dirty_q <= '0;
        end
        else if (fill)
        begin
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= 1'b0;   // Fresh copy of memory
        end
        else if (cmd_i.wr_en)
            dirty_q[idx] <= 1'b1;
        else if (cmd_i.mem_wr)
            dirty_q[victim_idx] <= 1'b0;
    end

    // Flush index, parked at zero outside a flush
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            flush_cnt <= '0;
        else if (cmd_i.clean_step)
            flush_cnt <= flush_cnt + 1'b1;
        else if (!cmd_i.clean_hold)
            flush_cnt <= '0;
    end

    // One-cycle memory strobes
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            rd_stb_q <= 1'b0;
            wr_stb_q <= 1'b0;
            fetch_q  <= 1'b0;
        end
        else
        begin
            rd_stb_q <= fetch_start;
            wr_stb_q <= cmd_i.mem_wr;
            fetch_q  <= cmd_i.mem_rd;
        end
    end

    always_ff @(posedge clk)
    begin
        if (cmd_i.mem_wr)
        begin
            // Victim goes back under its own stored tag
            mem_addr_q <= {tag_mem[victim_idx], victim_idx, {`CACHE_OFFSET_W{1'b0}}};
            mem_data_q <= line_mem[victim_idx];
        end
        else if (fetch_start)
            mem_addr_q <= {cpu_addr_i.tag, idx, {`CACHE_OFFSET_W{1'b0}}};
    end

    always_comb
    begin
        mem_req_o.addr = mem_addr_q;
        mem_req_o.data = mem_data_q;
        mem_req_o.rd   = rd_stb_q;
        mem_req_o.wr   = wr_stb_q;
    end

    a_wr_needs_hit: assert property (@(posedge clk) disable iff (!rst)
        cmd_i.wr_en |-> status_o.hit)
        else $error("Word write issued on a tag miss");

    a_one_strobe: assert property (@(posedge clk) disable iff (!rst)
        !(mem_req_o.rd && mem_req_o.wr))
        else $error("Memory read and write strobes fired together");

endmodule

`default_nettype wire

//--- cache/cache_controller.sv
`timescale 1ns/1ps
`default_nettype none

module cache_controller (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        cpu_req_i,
    input  wire                        cpu_we_i,
    input  wire                        flush_i,
    input  wire cache_pkg::dp_status_t status_i,
    input  wire                        mem_ack_i,
    output cache_pkg::ctrl_cmd_t       cmd_o,
    output logic                       done_o,
    output logic                       flush_done_o
);
    cache_pkg::ctrl_state_e state_q;
    cache_pkg::ctrl_state_e state_d;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            state_q <= cache_pkg::IDLE;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d      = state_q;
        cmd_o        = '0;
        done_o       = 1'b0;
        flush_done_o = 1'b0;

        case (state_q)
            cache_pkg::IDLE:
            begin
                if (flush_i)
                    state_d = cache_pkg::FLUSH_SCAN;   // Flush wins over a request
                else if (cpu_req_i)
                    state_d = cache_pkg::COMPARE;
            end

            cache_pkg::COMPARE:
            begin
                if (status_i.hit)
                begin
                    cmd_o.wr_en = cpu_we_i;
                    cmd_o.rd_en = !cpu_we_i;
                    done_o      = 1'b1;
                    state_d     = cache_pkg::IDLE;
                end
                else if (status_i.victim_dirty)
                begin
                    cmd_o.mem_wr = 1'b1;
                    state_d      = cache_pkg::WRITEBACK;
                end
                else
                    state_d = cache_pkg::FETCH;
            end

            cache_pkg::WRITEBACK:
            begin
                if (mem_ack_i)
                    state_d = cache_pkg::FETCH;
            end

            // Line gets installed in the ack cycle, then the access retries
            cache_pkg::FETCH:
            begin
                cmd_o.mem_rd = 1'b1;
                if (mem_ack_i)
                    state_d = cache_pkg::COMPARE;
            end

            cache_pkg::FLUSH_SCAN:
            begin
                if (status_i.flush_dirty)
                begin
                    cmd_o.mem_wr     = 1'b1;
                    cmd_o.clean_hold = 1'b1;
                    state_d          = cache_pkg::FLUSH_WB;
                end
                else if (status_i.flush_last)
                    state_d = cache_pkg::FLUSH_DONE;
                else
                    cmd_o.clean_step = 1'b1;
            end

            cache_pkg::FLUSH_WB:
            begin
                if (mem_ack_i)
                begin
                    cmd_o.clean_step = 1'b1;
                    if (status_i.flush_last)
                        state_d = cache_pkg::FLUSH_DONE;
                    else
                        state_d = cache_pkg::FLUSH_SCAN;
                end
                else
                    cmd_o.clean_hold = 1'b1;   // Stall on this index
            end

            cache_pkg::FLUSH_DONE:
            begin
                flush_done_o = 1'b1;           // Held until flush_i drops
                if (!flush_i)
                    state_d = cache_pkg::IDLE;
            end

            default:
                state_d = cache_pkg::IDLE;
        endcase
    end

    a_no_req_in_flush: assert property (@(posedge clk) disable iff (!rst)
        flush_i |-> !cpu_req_i)
        else $error("Processor request raised during a flush");

    a_done_with_req: assert property (@(posedge clk) disable iff (!rst)
        done_o |-> cpu_req_i)
        else $error("done_o pulsed with no request pending");

endmodule

`default_nettype wire

//--- logic/line_memory.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module line_memory (
    input  wire                      clk,
    input  wire                      rst,
    input  wire cache_pkg::mem_req_t req_i,
    output cache_pkg::mem_rsp_t      rsp_o
);
    localparam int ADDR_W = $clog2(`MEM_LINES);
    localparam int WORDS  = `CACHE_LINE_W / `CACHE_WORD_W;

    logic [`CACHE_LINE_W-1:0] mem [`MEM_LINES];
    logic [`MEM_LATENCY-1:0]  pend_q;      // Strobe in flight, one bit per cycle
    logic [`CACHE_LINE_W-1:0] rd_line_q;
    logic [ADDR_W-1:0]        line_addr;
    logic                     strobe;

    assign line_addr = req_i.addr[`CACHE_OFFSET_W +: ADDR_W];   // Bits 13:4
    assign strobe    = req_i.rd || req_i.wr;

    // Each word powers up holding its own byte address
    initial
    begin
        for (int l = 0; l < `MEM_LINES; l++)
        begin
            for (int w = 0; w < WORDS; w++)
            begin
                mem[l][w*`CACHE_WORD_W +: `CACHE_WORD_W] = `CACHE_WORD_W'(l * 16 + w * 4);
            end
        end
    end

    always @(posedge clk)
    begin
        if (req_i.wr)
            mem[line_addr] <= req_i.data;
        if (req_i.rd)
            rd_line_q <= mem[line_addr];   // Held until the ack
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            pend_q <= '0;
        else
            pend_q <= {pend_q[`MEM_LATENCY-2:0], strobe};
    end

    always_comb
    begin
        rsp_o.data = rd_line_q;
        rsp_o.ack  = pend_q[`MEM_LATENCY-1];
    end

    a_single_outstanding: assert property (@(posedge clk) disable iff (!rst)
        strobe |-> (pend_q == '0))
        else $error("New memory strobe while a request is pending");

endmodule

`default_nettype wire

//--- logic/cache_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module cache_subsys (
    input  wire         clk,
    input  wire         rst,
    input  wire         cpu_req_i,
    input  wire         cpu_we_i,
    input  wire [31:0]  cpu_addr_i,
    input  wire [31:0]  cpu_wdata_i,
    input  wire         flush_i,
    output logic [31:0] rdata_o,
    output logic        done_o,
    output logic        flush_done_o
);
    cache_pkg::ctrl_cmd_t  cmd;
    cache_pkg::dp_status_t status;
    cache_pkg::mem_req_t   mem_req;
    cache_pkg::mem_rsp_t   mem_rsp;

    cache_controller ctrl_inst (
        .clk          (clk),
        .rst          (rst),
        .cpu_req_i    (cpu_req_i),
        .cpu_we_i     (cpu_we_i),
        .flush_i      (flush_i),
        .status_i     (status),
        .mem_ack_i    (mem_rsp.ack),
        .cmd_o        (cmd),
        .done_o       (done_o),
        .flush_done_o (flush_done_o)
    );

    cache_datapath dp_inst (
        .clk         (clk),
        .rst         (rst),
        .cpu_addr_i  (cpu_addr_i),    // Split into tag, index, offset
        .cpu_wdata_i (cpu_wdata_i),
        .cmd_i       (cmd),
        .mem_rsp_i   (mem_rsp),
        .mem_req_o   (mem_req),
        .rdata_o     (rdata_o),
        .status_o    (status)
    );

    line_memory mem_inst (
        .clk   (clk),
        .rst   (rst),
        .req_i (mem_req),
        .rsp_o (mem_rsp)
    );

endmodule

`default_nettype wire

//--- dv/cache_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module cache_subsys_tb;

    localparam int N_REQ     = 240;   // All processor requests of all tests, with margin
    localparam int WD_CYCLES = (N_REQ * (2 + 2 * `MEM_LATENCY + 4)
                               + 256 * (`MEM_LATENCY + 3)) * 2;

    logic        clk;
    logic        rst;
    logic        cpu_req_i;
    logic        cpu_we_i;
    logic [31:0] cpu_addr_i;
    logic [31:0] cpu_wdata_i;
    logic        flush_i;
    logic [31:0] rdata_o;
    logic        done_o;
    logic        flush_done_o;

    logic [31:0] model [logic [31:0]];   // Last written word per byte address
    logic [31:0] exp_rdata;
    logic        hit_expected;
    logic [31:0] lcg_state;
    logic [31:0] r;
    int          errors;
    int          n_ok;
    int          n_bad;
    int          err_mark;

    cache_subsys cache_subsys_inst (
        .clk          (clk),
        .rst          (rst),
        .cpu_req_i    (cpu_req_i),
        .cpu_we_i     (cpu_we_i),
        .cpu_addr_i   (cpu_addr_i),
        .cpu_wdata_i  (cpu_wdata_i),
        .flush_i      (flush_i),
        .rdata_o      (rdata_o),
        .done_o       (done_o),
        .flush_done_o (flush_done_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Unwritten words still hold the memory's power-up value
    function automatic logic [31:0] model_word(input logic [31:0] addr);
        return model.exists(addr) ? model[addr] : addr;
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    a_read_data: assert property (@(posedge clk) disable iff (!rst)
        (done_o && !cpu_we_i) |-> (rdata_o == exp_rdata))
        else
        begin
            errors = errors + 1;
            $display("Error at %0t: rdata_o = %h, expected %h", $time, $sampled(rdata_o),
                exp_rdata);
        end

    // IDLE then COMPARE, done in the second cycle
    a_hit_timing: assert property (@(posedge clk) disable iff (!rst)
        ($rose(cpu_req_i) && hit_expected) |=> done_o)
        else
        begin
            errors = errors + 1;
            $display("Error at %0t: done_o = 0, expected 1 on a hit", $time);
        end

    a_flush_hold: assert property (@(posedge clk) disable iff (!rst)
        (flush_done_o && flush_i) |=> flush_done_o)
        else
        begin
            errors = errors + 1;
            $display("Error at %0t: flush_done_o = 0, expected 1 while flush_i held", $time);
        end

    // Done may linger for the cycle in which flush_i drops
    a_flush_done_cause: assert property (@(posedge clk) disable iff (!rst)
        flush_done_o |-> $past(flush_i))
        else
        begin
            errors = errors + 1;
            $display("flush_done_o went high at %0t with no flush requested", $time);
        end

    a_reset_state: assert property (@(posedge clk)
        $rose(rst) |-> (!done_o && !flush_done_o && !cache_subsys_inst.mem_req.rd
            && !cache_subsys_inst.mem_req.wr && cache_subsys_inst.dp_inst.valid_q == '0
            && cache_subsys_inst.dp_inst.dirty_q == '0))
        else
        begin
            errors = errors + 1;
            $display("Outputs or valid and dirty bits not cleared by reset at %0t", $time);
        end

    // One processor request, held until done_o
    task automatic access(input logic we, input logic [31:0] addr, input logic [31:0] data,
                          input logic expect_hit);
        @(posedge clk);
        #1;
        exp_rdata    = we ? 32'h0 : model_word(addr);
        hit_expected = expect_hit;
        cpu_we_i     = we;
        cpu_addr_i   = addr;
        cpu_wdata_i  = data;
        cpu_req_i    = 1'b1;
        do
        begin
            @(posedge clk);
            #1;
        end
        while (!done_o);
        @(posedge clk);
        #1;
        cpu_req_i    = 1'b0;
        hit_expected = 1'b0;
        if (we)
            model[addr] = data;
    endtask

    task automatic flush_cache();
        @(posedge clk);
        #1;
        flush_i = 1'b1;
        do
        begin
            @(posedge clk);
            #1;
        end
        while (!flush_done_o);
        repeat (3) @(posedge clk);   // Done must hold with flush_i
        #1;
        flush_i = 1'b0;
    endtask

    task automatic report_result(input string name);
        if (errors == err_mark)
        begin
            n_ok = n_ok + 1;
            $display("[%0t] %s: ok", $time, name);
        end
        else
        begin
            n_bad = n_bad + 1;
            $display("[%0t] %s: FAILED with %0d errors", $time, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial
    begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WD_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial
    begin
        rst          = 1'b0;
        cpu_req_i    = 1'b0;
        cpu_we_i     = 1'b0;
        cpu_addr_i   = '0;
        cpu_wdata_i  = '0;
        flush_i      = 1'b0;
        exp_rdata    = '0;
        hit_expected = 1'b0;
        lcg_state    = 32'd71968;
        errors       = 0;
        n_ok         = 0;
        n_bad        = 0;
        err_mark     = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (10) @(posedge clk);       // Quiet after reset

        access(1'b0, 32'h0000_0104, '0, 1'b0);
        access(1'b0, 32'h0000_2A38, '0, 1'b0);
        access(1'b0, 32'h0000_3FFC, '0, 1'b0);
        access(1'b0, 32'h0000_0010, '0, 1'b0);
        report_result("cold reads");

        access(1'b1, 32'h0000_0240, 32'hDEAD_BEEF, 1'b0);
        access(1'b0, 32'h0000_0240, '0, 1'b1);
        report_result("write then read hit");

        // Same index, tag differs by one
        access(1'b1, 32'h0000_0588, 32'h1234_5678, 1'b0);
        access(1'b0, 32'h0000_1588, '0, 1'b0);
        access(1'b0, 32'h0000_0588, '0, 1'b0);
        report_result("dirty eviction");

        for (int i = 0; i < 4; i++)
            access(1'b1, 32'h0000_0800 + i * 32'h44, 32'hA5A5_0000 + i, 1'b0);
        flush_cache();
        for (int i = 0; i < 4; i++)
            access(1'b0, 32'h0000_0800 + i * 32'h44, '0, 1'b1);
        for (int i = 0; i < 4; i++)
            access(1'b0, 32'h0000_2800 + i * 32'h44, '0, 1'b0);
        for (int i = 0; i < 4; i++)
            access(1'b0, 32'h0000_0800 + i * 32'h44, '0, 1'b0);
        report_result("flush");

        // Four tags over sixteen indices
        for (int i = 0; i < 200; i++)
        begin
            r = lcg_next() >> 8;
            access(r[8], {18'd0, r[1:0], 4'd0, r[5:2], r[7:6], 2'b00}, lcg_next(), 1'b0);
        end
        report_result("random traffic");

        $display("Tests: %0d ok, %0d failing, %0d check errors", n_ok, n_bad, errors);
        if (errors == 0 && n_bad == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- cache_subsys.f
+incdir+common
common/cache_pkg.sv
cache/cache_datapath.sv
cache/cache_controller.sv
logic/line_memory.sv
logic/cache_subsys.sv
dv/cache_subsys_tb.sv
